// File: hdl/cla16.sv
// combinational 16-bit add with no carry in or out; the result wraps modulo 2^16
`timescale 1ns/1ps
`default_nettype none

module cla16 (
  input  logic [15:0] a,
  input  logic [15:0] b,
  output logic [15:0] sum
);

  logic [15:0] p;
  logic [15:0] g;
  logic [15:0] c;     // carry into each bit
  logic [2:0]  gp;    // group propagate
  logic [2:0]  gg;    // group generate
  logic [3:0]  gc;    // carry into each group

  assign p = a ^ b;
  assign g = a & b;

  for (genvar k = 0; k < 4; k++) begin : g_grp
    logic [3:0] pk;
    logic [3:0] gk;
    assign pk = p[4*k +: 4];
    assign gk = g[4*k +: 4];
    assign c[4*k]   = gc[k];
    assign c[4*k+1] = gk[0] | (pk[0] & gc[k]);
    assign c[4*k+2] = gk[1] | (pk[1] & gk[0]) | (pk[1] & pk[0] & gc[k]);
    assign c[4*k+3] = gk[2] | (pk[2] & gk[1]) | (pk[2] & pk[1] & gk[0]) |
                      (pk[2] & pk[1] & pk[0] & gc[k]);
    if (k < 3) begin : g_pg   // top group only feeds the dropped carry out
      assign gp[k] = &pk;
      assign gg[k] = gk[3] | (pk[3] & gk[2]) | (pk[3] & pk[2] & gk[1]) |
                     (pk[3] & pk[2] & pk[1] & gk[0]);
    end
  end

  // lookahead carry unit
  assign gc[0] = 1'b0;
  assign gc[1] = gg[0];
  assign gc[2] = gg[1] | (gp[1] & gg[0]);
  assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0]);

  assign sum = p ^ c;

endmodule

`default_nettype wire

// File: hdl/fc_lane_if.sv
// work items from the receiver to the lanes; only the lane named in lane_sel acts on a load
`timescale 1ns/1ps
`default_nettype none

interface fc_lane_if;
  import fc_pkg::*;

  logic     load;       // single-cycle strobe
  fc_lane_t lane_sel;   // target lane
  fc_word_t feat;       // four feature bytes
  fc_word_t weight;     // four weights in the same byte order
  logic     first;      // word starts a neuron sum
  logic     last;       // word ends a neuron sum

  // receiver side
  modport rx (output load, lane_sel, feat, weight, first, last);

  // mac lanes
  modport lane (input load, lane_sel, feat, weight, first, last);

endinterface

`default_nettype wire

// File: hdl/fc_params.svh
// sizing for the fc engine; stream words are 32 bits and the lane count must stay 4
`ifndef FC_PARAMS_SVH
`define FC_PARAMS_SVH

// stream word width in bits
`define FC_DATA_W 32

// lanes per neuron group, one neuron each
`define FC_LANES 4

// register stages in the signed multiplier
`define FC_MULT_STAGES 8

// feature buffer depth in 32-bit words
`define FC_FEAT_DEPTH 256

`endif

// File: hdl/fc_pkg.sv
// shared types of the fc engine; bytes are two's complement and sums wrap modulo 2^16
`default_nettype none

`include "fc_params.svh"

package fc_pkg;

  // one signed feature or weight
  typedef logic signed [7:0] fc_byte_t;

  // four bytes, byte i in bits 8i+7..8i
  typedef logic [`FC_DATA_W-1:0] fc_word_t;

  typedef logic [15:0] fc_sum_t;    // product or running sum

  // feature word index
  typedef logic [$clog2(`FC_FEAT_DEPTH)-1:0] fc_addr_t;

  typedef logic [$clog2(`FC_LANES)-1:0] fc_lane_t;    // lane number

endpackage

`default_nettype wire

// File: hdl/fc_top.sv
// plain valid/ready streams; cmd_load and cmd_run are one-cycle strobes taken only when idle
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module fc_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  s_tvalid,
  output logic                  s_tready,
  input  logic [`FC_DATA_W-1:0] s_tdata,
  input  logic                  cmd_load,
  input  logic                  cmd_run,
  input  logic [8:0]            feat_words,   // 1..256
  input  logic [6:0]            groups,       // 1..64
  output logic                  feat_done,
  output logic                  run_done,
  output logic                  m_tvalid,
  input  logic                  m_tready,
  output logic [`FC_DATA_W-1:0] m_tdata,
  output logic                  m_tlast
);
  import fc_pkg::*;

  fc_lane_if lane_bus ();

  logic [`FC_LANES-1:0] sum_valid;
  fc_sum_t              lane_sum [`FC_LANES];
  logic                 tx_busy;

  stream_rx i_stream_rx (
    .clk        (clk),
    .rstn       (rstn),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .cmd_load   (cmd_load),
    .cmd_run    (cmd_run),
    .feat_words (feat_words),
    .groups     (groups),
    .feat_done  (feat_done),
    .run_done   (run_done),
    .busy       (tx_busy),
    .lane_if    (lane_bus)
  );

  for (genvar j = 0; j < `FC_LANES; j++) begin : g_lane
    mac_lane #(.LANE_ID(fc_lane_t'(j))) i_mac_lane (
      .clk       (clk),
      .rstn      (rstn),
      .lane_if   (lane_bus),
      .sum_valid (sum_valid[j]),
      .sum       (lane_sum[j])
    );
  end

  result_tx i_result_tx (
    .clk       (clk),
    .rstn      (rstn),
    .sum_valid (sum_valid),
    .sum0      (lane_sum[0]),
    .sum1      (lane_sum[1]),
    .sum2      (lane_sum[2]),
    .sum3      (lane_sum[3]),
    .busy      (tx_busy),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tdata   (m_tdata),
    .m_tlast   (m_tlast)
  );

endmodule

`default_nettype wire

// File: hdl/feature_buffer.sv
// single port, read before write, one cycle read latency and no reset of contents
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module feature_buffer (
  input  logic              clk,
  input  logic              we,
  input  fc_pkg::fc_addr_t  addr,
  input  fc_pkg::fc_word_t  wdata,
  output fc_pkg::fc_word_t  rdata
);
  import fc_pkg::*;

  fc_word_t mem [`FC_FEAT_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];   // old word on a write cycle
  end

endmodule

`default_nettype wire

// File: hdl/mac_lane.sv
// one neuron per lane; loads for this lane must be at least four cycles apart
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module mac_lane #(
  parameter fc_pkg::fc_lane_t LANE_ID = '0
) (
  input  logic            clk,
  input  logic            rstn,
  fc_lane_if.lane         lane_if,
  output logic            sum_valid,
  output fc_pkg::fc_sum_t sum
);
  import fc_pkg::*;

  localparam int N = `FC_MULT_STAGES;

  logic     hit;
  fc_word_t feat_q;
  fc_word_t wgt_q;
  logic     first_q;
  logic     last_q;
  logic     ser_busy;
  logic [1:0] byte_idx;
  fc_byte_t a_q;
  fc_byte_t b_q;
  logic     in_valid;
  logic     in_first;
  logic     in_last;
  logic [N-1:0] first_sr;   // tags travel beside the multiplier
  logic [N-1:0] last_sr;
  logic     prod_valid;
  fc_sum_t  product;
  fc_sum_t  acc;
  fc_sum_t  acc_d;

  assign hit = lane_if.load && (lane_if.lane_sel == LANE_ID);

  ////////////////////////////////////////////////////////////////////////////
  // byte serializer

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ser_busy <= 1'b0;
      byte_idx <= '0;
      in_valid <= 1'b0;
      in_first <= 1'b0;
      in_last  <= 1'b0;
      first_sr <= '0;
      last_sr  <= '0;
    end else begin
      in_valid <= ser_busy;
      in_first <= ser_busy && first_q && byte_idx == 2'd0;
      in_last  <= ser_busy && last_q && byte_idx == 2'd3;
      first_sr <= {first_sr[N-2:0], in_first};
      last_sr  <= {last_sr[N-2:0], in_last};
      if (hit) begin
        ser_busy <= 1'b1;
        byte_idx <= '0;
      end else if (ser_busy) begin
        byte_idx <= byte_idx + 1'b1;
        if (byte_idx == 2'd3) ser_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      feat_q  <= lane_if.feat;
      wgt_q   <= lane_if.weight;
      first_q <= lane_if.first;
      last_q  <= lane_if.last;
    end
    a_q <= feat_q[8*byte_idx +: 8];
    b_q <= wgt_q[8*byte_idx +: 8];
    if (prod_valid) acc <= acc_d;
  end

  mult_pipe i_mult_pipe (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (in_valid),
    .a         (a_q),
    .b         (b_q),
    .out_valid (prod_valid),
    .product   (product)
  );

  // first product of a neuron restarts the sum
  cla16 i_cla16 (
    .a   (product),
    .b   (first_sr[N-1] ? 16'h0000 : acc),
    .sum (acc_d)
  );

  assign sum_valid = prod_valid && last_sr[N-1];
  assign sum       = acc_d;

  a_ser_free : assert property (@(posedge clk) disable iff (!rstn)
    hit |-> (!ser_busy || byte_idx == 2'd3))
    else $error("lane %0d loaded while serializing", LANE_ID);

endmodule

`default_nettype wire

// File: hdl/mult_pipe.sv
// signed 8x8 multiply with fixed latency of 8 cycles; a new pair may enter every cycle
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module mult_pipe (
  input  logic             clk,
  input  logic             rstn,
  input  logic             in_valid,
  input  fc_pkg::fc_byte_t a,
  input  fc_pkg::fc_byte_t b,
  output logic             out_valid,
  output fc_pkg::fc_sum_t  product
);
  import fc_pkg::*;

  localparam int N = `FC_MULT_STAGES;

  logic [7:0]  a_mag;
  logic [7:0]  b_mag;
  logic [7:0]  pp_q [8];      // partial products
  logic [5:0]  lo2_q [4];
  logic [2:0]  hi2a_q [4];
  logic [3:0]  hi2b_q [4];
  logic [9:0]  s3_d [4];
  logic [9:0]  s3_q [4];
  logic [7:0]  lo4_q [2];
  logic [2:0]  hi4a_q [2];
  logic [4:0]  hi4b_q [2];
  logic [11:0] s5_d [2];
  logic [11:0] s5_q [2];
  logic [9:0]  lo6_q;
  logic [2:0]  hi6a_q;
  logic [6:0]  hi6b_q;
  logic [6:0]  hi7_d;
  fc_sum_t     mag_q;
  logic [6:0]  sign_sr;       // result sign per stage
  logic [N-1:0] vld_sr;

  assign a_mag = a[7] ? ~a + 8'd1 : a;    // -128 gives 8'h80
  assign b_mag = b[7] ? ~b + 8'd1 : b;

  ////////////////////////////////////////////////////////////////////////////
  // high halves, each adds the carry out of the stage before

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      s3_d[i] = {5'(hi2a_q[i]) + 5'(hi2b_q[i]) + 5'(lo2_q[i][5]), lo2_q[i][4:0]};
    end
    for (int i = 0; i < 2; i++) begin
      s5_d[i] = {5'(hi4a_q[i]) + hi4b_q[i] + 5'(lo4_q[i][7]), lo4_q[i][6:0]};
    end
    hi7_d = 7'(hi6a_q) + hi6b_q + 7'(lo6_q[9]);
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : 8'h00;
    end
    for (int i = 0; i < 4; i++) begin
      lo2_q[i]  <= {1'b0, pp_q[2*i][4:0]} + {1'b0, pp_q[2*i+1][3:0], 1'b0};
      hi2a_q[i] <= pp_q[2*i][7:5];
      hi2b_q[i] <= pp_q[2*i+1][7:4];
      s3_q[i]   <= s3_d[i];
    end
    for (int i = 0; i < 2; i++) begin
      lo4_q[i]  <= {1'b0, s3_q[2*i][6:0]} + {1'b0, s3_q[2*i+1][4:0], 2'b00};
      hi4a_q[i] <= s3_q[2*i][9:7];
      hi4b_q[i] <= s3_q[2*i+1][9:5];
      s5_q[i]   <= s5_d[i];
    end
    lo6_q   <= {1'b0, s5_q[0][8:0]} + {1'b0, s5_q[1][4:0], 4'h0};
    hi6a_q  <= s5_q[0][11:9];
    hi6b_q  <= s5_q[1][11:5];
    mag_q   <= {hi7_d, lo6_q[8:0]};
    sign_sr <= {sign_sr[5:0], a[7] ^ b[7]};
    product <= sign_sr[6] ? ~mag_q + 16'd1 : mag_q;   // sign fix
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[N-2:0], in_valid};
    end
  end

  assign out_valid = vld_sr[N-1];

endmodule

`default_nettype wire

// File: hdl/result_tx.sv
// expects all four lane sums of a group before the next group's first sum
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module result_tx (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [`FC_LANES-1:0]  sum_valid,
  input  fc_pkg::fc_sum_t       sum0,
  input  fc_pkg::fc_sum_t       sum1,
  input  fc_pkg::fc_sum_t       sum2,
  input  fc_pkg::fc_sum_t       sum3,
  output logic                  busy,
  output logic                  m_tvalid,
  input  logic                  m_tready,
  output logic [`FC_DATA_W-1:0] m_tdata,
  output logic                  m_tlast
);
  import fc_pkg::*;

  fc_sum_t sum_q [`FC_LANES];
  logic    second;    // high word pair on the bus

  // lane 0 and lane 2 in the low halves
  assign m_tdata = second ? {sum_q[3], sum_q[2]} : {sum_q[1], sum_q[0]};
  assign m_tlast = second;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy     <= 1'b0;
      m_tvalid <= 1'b0;
      second   <= 1'b0;
    end else begin
      if (|sum_valid) busy <= 1'b1;
      if (sum_valid[`FC_LANES-1]) m_tvalid <= 1'b1;   // fourth sum in
      if (m_tvalid && m_tready) begin
        if (second) begin
          m_tvalid <= 1'b0;
          second   <= 1'b0;
          busy     <= 1'b0;
        end else begin
          second <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid[0]) sum_q[0] <= sum0;
    if (sum_valid[1]) sum_q[1] <= sum1;
    if (sum_valid[2]) sum_q[2] <= sum2;
    if (sum_valid[3]) sum_q[3] <= sum3;
  end

  a_no_sum_in_send : assert property (@(posedge clk) disable iff (!rstn)
    (|sum_valid) |-> !m_tvalid)
    else $error("lane sum arrived while sending");

endmodule

`default_nettype wire

// File: hdl/stream_rx.sv
// commands are taken in idle only; feat_words is 1..256 and groups is 1..64
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module stream_rx (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 s_tvalid,
  output logic                 s_tready,
  input  logic [`FC_DATA_W-1:0] s_tdata,
  input  logic                 cmd_load,
  input  logic                 cmd_run,
  input  logic [8:0]           feat_words,
  input  logic [6:0]           groups,
  output logic                 feat_done,
  output logic                 run_done,
  input  logic                 busy,
  fc_lane_if.rx                lane_if
);
  import fc_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_LOAD, S_RUN} state_t;

  state_t   state;
  fc_addr_t word_idx;     // write address in load, feature word in run
  fc_addr_t word_last;    // index of the final feature word
  fc_lane_t lane_idx;
  logic [5:0] grp_idx;
  logic [5:0] grp_last;
  logic     grp_pend;     // a group's sums are not yet sent
  logic     busy_q;
  logic     xfer;
  logic     grp_start;
  logic     grp_end;
  fc_word_t rd_word;

  assign grp_start = (lane_idx == '0) && (word_idx == '0);
  assign grp_end   = (lane_idx == '1) && (word_idx == word_last);

  // hold off a new group until the previous one has left result_tx
  assign s_tready = (state == S_LOAD) ||
                    (state == S_RUN && !(grp_start && (busy || grp_pend)));
  assign xfer = s_tvalid && s_tready;

  feature_buffer i_feature_buffer (
    .clk   (clk),
    .we    (state == S_LOAD && xfer),
    .addr  (word_idx),
    .wdata (s_tdata),
    .rdata (rd_word)
  );

  ////////////////////////////////////////////////////////////////////////////
  // controller

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= S_IDLE;
      word_idx  <= '0;
      word_last <= '0;
      lane_idx  <= '0;
      grp_idx   <= '0;
      grp_last  <= '0;
      grp_pend  <= 1'b0;
      busy_q    <= 1'b0;
      feat_done <= 1'b0;
      run_done  <= 1'b0;
    end else begin
      feat_done <= 1'b0;
      run_done  <= 1'b0;
      busy_q    <= busy;
      if (state == S_RUN && xfer && grp_end) begin
        grp_pend <= 1'b1;
      end else if (busy_q && !busy) begin   // second output word went out
        grp_pend <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          word_idx <= '0;
          lane_idx <= '0;
          grp_idx  <= '0;
          if (cmd_load) begin
            state     <= S_LOAD;
            word_last <= fc_addr_t'(feat_words - 9'd1);
          end else if (cmd_run) begin
            state    <= S_RUN;
            grp_last <= 6'(groups - 7'd1);
          end
        end
        S_LOAD: begin
          if (xfer) begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == word_last) begin
              state     <= S_IDLE;
              feat_done <= 1'b1;
            end
          end
        end
        S_RUN: begin
          if (xfer) begin
            lane_idx <= lane_idx + 1'b1;    // one weight word per lane
            if (lane_idx == '1) begin
              word_idx <= word_idx + 1'b1;
              if (word_idx == word_last) begin
                word_idx <= '0;
                grp_idx  <= grp_idx + 1'b1;
                if (grp_idx == grp_last) begin
                  state    <= S_IDLE;
                  run_done <= 1'b1;
                end
              end
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lane loads, one cycle behind the accepted weight word

  always_ff @(posedge clk) begin
    if (!rstn) begin
      lane_if.load <= 1'b0;
    end else begin
      lane_if.load <= (state == S_RUN) && xfer;
    end
  end

  always_ff @(posedge clk) begin
    lane_if.lane_sel <= lane_idx;
    lane_if.weight   <= s_tdata;
    lane_if.first    <= word_idx == '0;
    lane_if.last     <= word_idx == word_last;
  end

  assign lane_if.feat = rd_word;    // read data lines up with the weight

  a_cmd_idle : assert property (@(posedge clk) disable iff (!rstn)
    (cmd_load || cmd_run) |-> state == S_IDLE)
    else $error("command while not idle");

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/fc_pkg.sv
hdl/fc_lane_if.sv
hdl/feature_buffer.sv
hdl/mult_pipe.sv
hdl/cla16.sv
hdl/mac_lane.sv
hdl/stream_rx.sv
hdl/result_tx.sv
hdl/fc_top.sv
test/fc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fc_tb simulation with Verilator, exit status 1 on failure
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f project.f --top-module fc_tb -o fc_sim &&
./obj_dir/fc_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: test/fc_tb.sv
// directed tests of fc_top; every failed check stops the run, and the watchdog bounds the run time
`timescale 1ns/1ps
`default_nettype none

`include "fc_params.svh"

module fc_tb;

  localparam int CLK_PERIOD = 10;
  // feature and weight words streamed in over all tests
  localparam int FEAT_ALL   = 8 + 2 + 16 + 4;
  localparam int WGT_ALL    = 4 * (1 * 2 + 5 * 16 + 5 * 16 + 3 * 4);
  localparam int GROUPS_ALL = 1 + 5 + 5 + 3;
  localparam int LIMIT      = 4 * (FEAT_ALL + WGT_ALL) + 80 * GROUPS_ALL + 500;

  logic                  clk;
  logic                  rstn;
  logic                  s_tvalid;
  logic                  s_tready;
  logic [`FC_DATA_W-1:0] s_tdata;
  logic                  cmd_load;
  logic                  cmd_run;
  logic [8:0]            feat_words;
  logic [6:0]            groups;
  logic                  feat_done;
  logic                  run_done;
  logic                  m_tvalid;
  logic                  m_tready;
  logic [`FC_DATA_W-1:0] m_tdata;
  logic                  m_tlast;

  logic [31:0] data_state;
  logic [31:0] bp_state;
  logic        bp_on;            // random m_tready when set
  logic [31:0] feat_mem [256];   // model copy of the feature buffer
  logic [31:0] in_words [$];     // next input stream
  logic [31:0] exp_data [$];
  logic        exp_last [$];
  int          in_xfers;
  int          feat_done_cnt;
  int          run_done_cnt;
  logic        held_valid;
  logic [31:0] held_data;
  string       test_name;

  fc_top i_fc_top (
    .clk        (clk),
    .rstn       (rstn),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .cmd_load   (cmd_load),
    .cmd_run    (cmd_run),
    .feat_words (feat_words),
    .groups     (groups),
    .feat_done  (feat_done),
    .run_done   (run_done),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready),
    .m_tdata    (m_tdata),
    .m_tlast    (m_tlast)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("watchdog expired in test %s, the run is stuck", test_name);
    $display("ERRORS FOUND");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic fail_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic fail_msg(input string msg);
    $display("test %s: %s", test_name, msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    data_state = xorshift(data_state);
    return data_state;
  endfunction

  // signed dot product of four byte pairs
  function automatic int dot4(input logic [31:0] f, input logic [31:0] w);
    int s;
    s = 0;
    for (int i = 0; i < 4; i++) begin
      s += int'($signed(f[8*i +: 8])) * int'($signed(w[8*i +: 8]));
    end
    return s;
  endfunction

  task automatic fill_random(input int n);
    in_words.delete();
    repeat (n) in_words.push_back(next_rand());
  endtask

  task automatic fill_extreme(input int n);
    logic [7:0]  ext [4] = '{8'h80, 8'h7f, 8'hff, 8'h00};
    logic [31:0] w;
    in_words.delete();
    repeat (n) begin
      w = next_rand();
      in_words.push_back({ext[w[7:6]], ext[w[5:4]], ext[w[3:2]], ext[w[1:0]]});
    end
  endtask

  task automatic issue_cmd(input logic is_load, input int count);
    if (is_load) begin
      cmd_load   = 1'b1;
      feat_words = 9'(count);
    end else begin
      cmd_run = 1'b1;
      groups  = 7'(count);
    end
    @(negedge clk);
    cmd_load = 1'b0;
    cmd_run  = 1'b0;
  endtask

  // valid stays high until each word is taken
  task automatic send_stream();
    foreach (in_words[i]) begin
      s_tvalid = 1'b1;
      s_tdata  = in_words[i];
      @(posedge clk);
      while (!s_tready) @(posedge clk);
      @(negedge clk);
    end
    s_tvalid = 1'b0;
  endtask

  // extra is the count of valid cycles offered after the last word
  task automatic load_features(input int n, input int extra);
    int xfer_before;
    int done_before;
    xfer_before = in_xfers;
    done_before = feat_done_cnt;
    for (int k = 0; k < n; k++) feat_mem[k] = in_words[k];
    issue_cmd(1'b1, n);
    assert (s_tready) else fail_msg("s_tready did not rise after cmd_load");
    send_stream();
    s_tvalid = extra > 0;
    s_tdata  = 32'hdead_beef;
    repeat (extra) @(negedge clk);
    s_tvalid = 1'b0;
    while (feat_done_cnt == done_before) @(negedge clk);
    repeat (2) @(negedge clk);
    assert (in_xfers == xfer_before + n)
      else fail_value("words accepted", xfer_before + n, in_xfers);
    assert (feat_done_cnt == done_before + 1)
      else fail_value("feat_done pulses", done_before + 1, feat_done_cnt);
  endtask

  // weights in in_words are ordered by group, feature word and lane
  task automatic run_groups(input int ng, input int nf);
    int acc [4];
    int done_before;
    done_before = run_done_cnt;
    for (int g = 0; g < ng; g++) begin
      for (int j = 0; j < 4; j++) acc[j] = 0;
      for (int k = 0; k < nf; k++) begin
        for (int j = 0; j < 4; j++) begin
          acc[j] += dot4(feat_mem[k], in_words[(g * nf + k) * 4 + j]);
        end
      end
      exp_data.push_back({acc[1][15:0], acc[0][15:0]});
      exp_last.push_back(1'b0);
      exp_data.push_back({acc[3][15:0], acc[2][15:0]});
      exp_last.push_back(1'b1);
    end
    issue_cmd(1'b0, ng);
    send_stream();
    while (exp_data.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    assert (run_done_cnt == done_before + 1)
      else fail_value("run_done pulses", done_before + 1, run_done_cnt);
    assert (!m_tvalid) else fail_msg("m_tvalid still high after the last expected word");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitors, output collector and back-pressure

  always @(posedge clk) begin
    if (rstn) begin
      if (s_tvalid && s_tready) in_xfers++;
      if (feat_done) feat_done_cnt++;
      if (run_done) run_done_cnt++;
      if (held_valid) begin   // stalled word must not move
        assert (m_tvalid && m_tdata == held_data)
          else fail_msg("output word changed while m_tready was low");
      end
      if (m_tvalid && m_tready) begin
        assert (exp_data.size() > 0) else fail_msg("output word arrived with none expected");
        assert (m_tdata == exp_data[0]) else fail_value("m_tdata", exp_data[0], m_tdata);
        assert (m_tlast == exp_last[0])
          else fail_value("m_tlast", 32'(exp_last[0]), 32'(m_tlast));
        void'(exp_data.pop_front());
        void'(exp_last.pop_front());
      end
      held_valid = m_tvalid && !m_tready;
      held_data  = m_tdata;
    end
  end

  always @(negedge clk) begin
    if (bp_on) begin
      bp_state = xorshift(bp_state);
      m_tready = bp_state[0];
    end else begin
      m_tready = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests

  initial begin
    rstn       = 1'b0;
    s_tvalid   = 1'b0;
    s_tdata    = '0;
    cmd_load   = 1'b0;
    cmd_run    = 1'b0;
    feat_words = '0;
    groups     = '0;
    m_tready   = 1'b1;
    data_state = 32'he525;
    bp_state   = 32'he525;
    bp_on      = 1'b0;
    held_valid = 1'b0;
    held_data  = '0;
    in_xfers      = 0;
    feat_done_cnt = 0;
    run_done_cnt  = 0;
    test_name  = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    assert (!s_tready && !m_tvalid && !feat_done && !run_done)
      else fail_msg("outputs not low after reset");

    test_name = "feature_load";
    fill_random(8);
    load_features(8, 4);    // extra valid cycles must not be taken

    test_name = "known_values";
    fill_extreme(2);
    load_features(2, 0);
    fill_extreme(8);
    run_groups(1, 2);

    test_name = "random_run";
    fill_random(16);
    load_features(16, 0);
    fill_random(5 * 16 * 4);
    run_groups(5, 16);

    test_name = "back_pressure";
    bp_on = 1'b1;
    fill_random(5 * 16 * 4);
    run_groups(5, 16);
    bp_on = 1'b0;

    test_name = "reload";
    fill_random(4);
    load_features(4, 0);
    fill_random(3 * 4 * 4);
    run_groups(3, 4);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
